// File: soc_pkg.sv
package soc_pkg;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------

    // One bus data word.
    typedef logic [31:0] word_t;

    // Byte-write enables. Bit n enables byte n.
    typedef logic [3:0] wmask_t;

    // Word address inside the I/O window.
    typedef logic [5:0] waddr_t;

    // One console character.
    typedef logic [7:0] byte_t;

    // ----------------------------------------
    // Memory map, in words
    // ----------------------------------------

    // Tail index sits in byte 3.
    localparam waddr_t ADDR_TAIL = 6'd0;

    // First ring entry.
    // Entry k is at word 1 + k, with its character in byte 3.
    localparam waddr_t ADDR_FIFO_BASE = 6'd1;

    // Board LED word, bits 0 to 4 in use.
    localparam waddr_t ADDR_LED = 6'd33;

    // Size of the window.
    localparam int MMIO_WORDS = 34;

endpackage

// File: console_mmio.sv
`timescale 1ns/1ps

module console_mmio #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tick,
    input  soc_pkg::waddr_t               addr,
    input  logic                          wen,
    input  logic                          rd,
    input  soc_pkg::wmask_t               wmask,
    input  soc_pkg::word_t                wdata,
    input  logic [$clog2(FIFO_DEPTH)-1:0] head,
    output soc_pkg::word_t                rdata,
    output logic                          data_ready,
    output logic [$clog2(FIFO_DEPTH)-1:0] tail,
    output soc_pkg::byte_t                head_char,
    output soc_pkg::word_t                led_word
);

    import soc_pkg::*;

    localparam int IDX_W = $clog2(FIFO_DEPTH);

    word_t  mem [MMIO_WORDS];
    logic   in_window;
    byte_t  tail_byte;
    waddr_t ring_addr;

    assign in_window = (addr < waddr_t'(MMIO_WORDS));

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    // Byte-masked write, taken once per tick.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MMIO_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (tick && wen && in_window) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------

    // Data_ready follows rd by one tick.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_ready <= 1'b0;
        end else if (tick) begin
            data_ready <= rd;
        end
    end

    // Word as it stood at the strobe tick.
    always_ff @(posedge clk) begin
        if (tick && rd) begin
            rdata <= in_window ? mem[addr] : '0;
        end
    end

    // ----------------------------------------
    // Console and LED taps
    // ----------------------------------------

    assign tail_byte = mem[ADDR_TAIL][31:24];
    // Power-of-two depth, so dropping upper bits is the modulo.
    assign tail      = tail_byte[IDX_W-1:0];

    assign ring_addr = ADDR_FIFO_BASE + waddr_t'(head);
    assign head_char = mem[ring_addr][31:24];

    assign led_word  = mem[ADDR_LED];

    // The bus issues at most one access per tick.
    a_no_rd_wen: assert property (
        @(posedge clk) disable iff (!rst_n)
        tick |-> !(rd && wen)
    );

endmodule

// File: console_drain.sv
`timescale 1ns/1ps

module console_drain #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tick,
    input  logic                          ready,
    input  logic [$clog2(FIFO_DEPTH)-1:0] tail,
    input  soc_pkg::byte_t                head_char,
    output logic [$clog2(FIFO_DEPTH)-1:0] head,
    output logic                          start,
    output soc_pkg::byte_t                data,
    output logic                          pending
);

    logic launch;

    assign pending = (head != tail);

    // A gap of one tick after each start lets the transmitter drop ready.
    assign launch = tick && !start && ready && pending;

    // ----------------------------------------
    // Head index and start pulse
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            start <= 1'b0;
        end else if (tick) begin
            if (launch) begin
                start <= 1'b1;
                head  <= head + 1'b1;
            end else begin
                start <= 1'b0;
            end
        end
    end

    // Character captured with the pulse.
    always_ff @(posedge clk) begin
        if (launch) begin
            data <= head_char;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------

    // Start is a single-tick pulse.
    a_start_one_tick: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tick && start) |=> !start
    );

    // Never launch into a busy transmitter.
    a_start_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(start) |-> $past(ready)
    );

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD_TICKS = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           tick,
    input  logic           start,
    input  soc_pkg::byte_t data,
    output logic           uart_tx,
    output logic           ready
);

    import soc_pkg::*;

    localparam int BAUD_W = (BAUD_TICKS > 1) ? $clog2(BAUD_TICKS) : 1;

    typedef enum logic [1:0] {
        IDLE,
        START_BIT,
        DATA_BITS,
        STOP_BIT
    } tx_state_t;

    tx_state_t         state;
    logic [BAUD_W-1:0] baud_cnt;
    logic [2:0]        bit_cnt;
    logic              baud_last;
    byte_t             shift_q;

    assign baud_last = (baud_cnt == BAUD_W'(BAUD_TICKS - 1));

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            uart_tx  <= 1'b1;
            ready    <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tick) begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= START_BIT;
                        uart_tx  <= 1'b0;
                        ready    <= 1'b0;
                        baud_cnt <= '0;
                    end
                end
                START_BIT: begin
                    if (baud_last) begin
                        state    <= DATA_BITS;
                        uart_tx  <= shift_q[0];
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                DATA_BITS: begin
                    if (baud_last) begin
                        baud_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            state   <= STOP_BIT;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            uart_tx <= shift_q[1];
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                STOP_BIT: begin
                    // Ready returns as the stop bit ends.
                    if (baud_last) begin
                        state    <= IDLE;
                        ready    <= 1'b1;
                        baud_cnt <= '0;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    state   <= IDLE;
                    uart_tx <= 1'b1;
                    ready   <= 1'b1;
                end
            endcase
        end
    end

    // LSB first, so shift right at the end of each data bit.
    always_ff @(posedge clk) begin
        if (tick && state == IDLE && start) begin
            shift_q <= data;
        end else if (tick && state == DATA_BITS && baud_last) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    // Idle line is mark.
    a_idle_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == IDLE) |-> uart_tx
    );

endmodule

// File: console_top.sv
`timescale 1ns/1ps

module console_top #(
    parameter int FIFO_DEPTH = 32,
    parameter int BAUD_TICKS = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  soc_pkg::waddr_t addr,
    input  logic            wen,
    input  logic            rd,
    input  soc_pkg::wmask_t wmask,
    input  soc_pkg::word_t  wdata,
    output soc_pkg::word_t  rdata,
    output logic            data_ready,
    output logic [5:0]      led,
    output logic            uart_tx
);

    import soc_pkg::*;

    localparam int IDX_W = $clog2(FIFO_DEPTH);

    logic [1:0]       tick_cnt;
    logic             tick;
    logic [IDX_W-1:0] tail;
    logic [IDX_W-1:0] head;
    byte_t            head_char;
    word_t            led_word;
    logic             start;
    byte_t            tx_data;
    logic             tx_ready;
    logic             pending;

    // ----------------------------------------
    // System tick, one clk in three
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= 2'd0;
        end else if (tick_cnt == 2'd2) begin
            tick_cnt <= 2'd0;
        end else begin
            tick_cnt <= tick_cnt + 2'd1;
        end
    end

    assign tick = (tick_cnt == 2'd0);

    // ----------------------------------------
    // Blocks
    // ----------------------------------------

    console_mmio #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) mmio0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .addr       (addr),
        .wen        (wen),
        .rd         (rd),
        .wmask      (wmask),
        .wdata      (wdata),
        .head       (head),
        .rdata      (rdata),
        .data_ready (data_ready),
        .tail       (tail),
        .head_char  (head_char),
        .led_word   (led_word)
    );

    console_drain #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) drain0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .ready     (tx_ready),
        .tail      (tail),
        .head_char (head_char),
        .head      (head),
        .start     (start),
        .data      (tx_data),
        .pending   (pending)
    );

    uart_tx #(
        .BAUD_TICKS (BAUD_TICKS)
    ) utx0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .start   (start),
        .data    (tx_data),
        .uart_tx (uart_tx),
        .ready   (tx_ready)
    );

    // Board LEDs are active low and wired in reverse order.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= 6'b111110;
        end else begin
            led[0]   <= pending;
            led[5:1] <= ~{led_word[0], led_word[1], led_word[2], led_word[3], led_word[4]};
        end
    end

endmodule

// File: tb_uart_rx.sv
`timescale 1ns/1ps

module tb_uart_rx #(
    parameter int BIT_CLKS = 12
) (
    input  logic           clk,
    input  logic           line,
    output logic           valid,
    output soc_pkg::byte_t data,
    output logic           frame_ok
);

    import soc_pkg::*;

    byte_t shift;
    logic  stop_seen;
    int    bit_idx;

    // Samples on the falling clk edge, away from the line's update edge.
    initial begin
        valid    <= 1'b0;
        data     <= '0;
        frame_ok <= 1'b0;
        forever begin
            @(negedge clk);
            if (line === 1'b0) begin
                // Move to the centre of the start bit.
                repeat (BIT_CLKS / 2) @(negedge clk);
                if (line === 1'b0) begin
                    for (bit_idx = 0; bit_idx < 8; bit_idx++) begin
                        repeat (BIT_CLKS) @(negedge clk);
                        shift[bit_idx] = line;
                    end
                    repeat (BIT_CLKS) @(negedge clk);
                    stop_seen = (line === 1'b1);
                    @(posedge clk);
                    data     <= shift;
                    frame_ok <= stop_seen;
                    valid    <= 1'b1;
                    @(posedge clk);
                    valid <= 1'b0;
                end
            end
        end
    end

endmodule

// File: tb_console.sv
`timescale 1ns/1ps

module tb_console;

    import soc_pkg::*;

    localparam int FIFO_DEPTH = 32;
    localparam int BAUD_TICKS = 4;
    localparam int CLK_NS     = 40;
    localparam int BIT_CLKS   = BAUD_TICKS * 3;
    localparam int MAX_CHARS  = 31 + 2 * FIFO_DEPTH + 12 + 8;
    localparam int WATCH_CLKS = MAX_CHARS * 10 * BIT_CLKS + 20000;

    logic       clk;
    logic       rst_n;
    waddr_t     addr;
    logic       wen;
    logic       rd;
    wmask_t     wmask;
    word_t      wdata;
    word_t      rdata;
    logic       data_ready;
    logic [5:0] led;
    logic       uart_line;
    logic       rx_valid;
    byte_t      rx_data;
    logic       rx_frame_ok;
    logic [1:0] tick_phase;

    // Reference model.
    word_t model_mem [MMIO_WORDS];
    int    tail_idx = 0;
    byte_t exp_q [$];

    int test_errors  = 0;
    int errors_total = 0;
    int checks       = 0;
    int rx_errors    = 0;
    int rx_checks    = 0;
    int rx_mark      = 0;

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // Tick phase counted from reset release.
    // Phase 0 marks a tick edge.
    always @(posedge clk) begin
        if (!rst_n || tick_phase == 2'd2) begin
            tick_phase <= 2'd0;
        end else begin
            tick_phase <= tick_phase + 2'd1;
        end
    end

    console_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .BAUD_TICKS (BAUD_TICKS)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wen        (wen),
        .rd         (rd),
        .wmask      (wmask),
        .wdata      (wdata),
        .rdata      (rdata),
        .data_ready (data_ready),
        .led        (led),
        .uart_tx    (uart_line)
    );

    tb_uart_rx #(
        .BIT_CLKS (BIT_CLKS)
    ) rx0 (
        .clk      (clk),
        .line     (uart_line),
        .valid    (rx_valid),
        .data     (rx_data),
        .frame_ok (rx_frame_ok)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic next_tick();
        @(posedge clk);
        while (tick_phase != 2'd0) begin
            @(posedge clk);
        end
    endtask

    task automatic write_word(input waddr_t a, input wmask_t m, input word_t d);
        next_tick();
        addr  <= a;
        wmask <= m;
        wdata <= d;
        wen   <= 1'b1;
        next_tick();
        wen <= 1'b0;
        if (a < MMIO_WORDS) begin
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    model_mem[a][8*b +: 8] = d[8*b +: 8];
                end
            end
        end
    endtask

    // Data_ready is low on the strobe tick, high one tick later and low again after that.
    task automatic read_check(input waddr_t a);
        next_tick();
        addr <= a;
        rd   <= 1'b1;
        @(negedge clk);
        check_value("data_ready", word_t'(data_ready), 32'd0);
        next_tick();
        rd <= 1'b0;
        @(negedge clk);
        check_value("data_ready", word_t'(data_ready), 32'd1);
        check_value("rdata", rdata, model_mem[a]);
        next_tick();
        @(negedge clk);
        check_value("data_ready", word_t'(data_ready), 32'd0);
    endtask

    task automatic push_string(input int n);
        byte_t ch;
        int    idx;
        for (int k = 0; k < n; k++) begin
            ch  = byte_t'($urandom);
            idx = (tail_idx + k) % FIFO_DEPTH;
            exp_q.push_back(ch);
            write_word(waddr_t'(ADDR_FIFO_BASE + idx), 4'b1000, {ch, 24'($urandom)});
        end
        tail_idx = (tail_idx + n) % FIFO_DEPTH;
        // Upper tail bits are noise that the index must drop.
        write_word(ADDR_TAIL, 4'b1000,
                   {(8'($urandom) & ~8'(FIFO_DEPTH - 1)) | 8'(tail_idx), 24'h0});
    endtask

    // Returns after the last stop bit has ended.
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    function automatic logic [4:0] led_expect(input word_t w);
        logic [4:0] e;
        for (int i = 0; i < 5; i++) begin
            e[4 - i] = ~w[i];
        end
        return e;
    endfunction

    task automatic finish_test(input int num, input string name);
        int fails;
        fails = test_errors + (rx_errors - rx_mark);
        rx_mark = rx_errors;
        errors_total += fails;
        test_errors = 0;
        $display("test %0d (%s) done, %0d errors", num, name, fails);
    endtask

    // ----------------------------------------
    // Received characters
    // ----------------------------------------

    always @(negedge clk) begin
        byte_t want;
        if (rx_valid) begin
            rx_checks++;
            assert (exp_q.size() != 0) else begin
                $display("received character %0h while none was expected", rx_data);
                rx_errors++;
            end
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (rx_data === want) else begin
                    $display("ERR %0t rx_data got %0h expected %0h", $time, rx_data, want);
                    rx_errors++;
                end
            end
            assert (rx_frame_ok === 1'b1) else begin
                $display("character %0h arrived without a valid stop bit", rx_data);
                rx_errors++;
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        int     n;
        int     sent;
        waddr_t a;
        void'($urandom(15));
        rst_n <= 1'b0;
        addr  <= '0;
        wen   <= 1'b0;
        rd    <= 1'b0;
        wmask <= '0;
        wdata <= '0;
        for (int i = 0; i < MMIO_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("uart_tx", word_t'(uart_line), 32'd1);
        check_value("data_ready", word_t'(data_ready), 32'd0);
        check_value("led", word_t'(led), 32'h3e);
        finish_test(1, "reset state");

        // Tail word is left alone so nothing drains here.
        for (int i = 0; i < 40; i++) begin
            a = waddr_t'(1 + $urandom % 63);
            write_word(a, wmask_t'($urandom), word_t'($urandom));
            read_check(waddr_t'(a % MMIO_WORDS));
        end
        finish_test(2, "masked write and read-back");

        n = 1 + $urandom % 31;
        push_string(n);
        wait_drain();
        check_value("led[0]", word_t'(led[0]), 32'd0);
        finish_test(3, "character order");

        sent = 0;
        while (sent < 2 * FIFO_DEPTH) begin
            n = 4 + $urandom % 9;
            while (exp_q.size() + n > FIFO_DEPTH - 1) begin
                @(negedge clk);
            end
            push_string(n);
            sent += n;
        end
        wait_drain();
        finish_test(4, "back-pressure and wrap");

        for (int i = 0; i < 12; i++) begin
            write_word(ADDR_LED, wmask_t'($urandom), word_t'($urandom));
            repeat (2) @(negedge clk);
            check_value("led[5:1]", word_t'(led[5:1]),
                        word_t'(led_expect(model_mem[ADDR_LED])));
        end
        finish_test(5, "LED word");

        n = 1 + $urandom % 8;
        push_string(n);
        repeat (2) @(negedge clk);
        check_value("led[0]", word_t'(led[0]), 32'd1);
        wait_drain();
        check_value("led[0]", word_t'(led[0]), 32'd0);
        finish_test(6, "pending indicator");

        $display("tests 6, checks %0d, errors %0d", checks + rx_checks, errors_total);
        if (errors_total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCH_CLKS * CLK_NS);
        $display("watchdog expired with %0d characters still expected", exp_q.size());
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: console_top.f
soc_pkg.sv
console_mmio.sv
console_drain.sv
uart_tx.sv
console_top.sv
tb_uart_rx.sv
tb_console.sv

// File: Makefile
TOP := tb_console

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f console_top.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
